// File: icache.f
verilog/cache_types.sv
verilog/mem_if.sv
verilog/inst_control.sv
verilog/inst_datapath.sv
verilog/prefetch_unit.sv
verilog/mem_arbiter.sv
verilog/icache.sv
tb/icache_checker.sv
tb/icache_tb.sv

// File: tb/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;
    import cache_types::*;

    localparam int mem_latency  = 3;       // cycles from read to resp
    localparam int resp_limit   = 80;      // per fetch or awaited read
    localparam int walk_fetches = 40;
    localparam int fetch_count  = 10 + walk_fetches;
    localparam int cycle_bound  = 30;      // miss queued behind a prefetch
    localparam int max_cycles   = fetch_count * cycle_bound + 300;
    localparam logic [word_w-1:0] fill_pattern = 32'h5a3c_96e1;

    logic              clk = 1'b0;
    logic              rst;
    logic [addr_w-1:0] cpu_addr;
    logic              cpu_read;
    logic [word_w-1:0] cpu_rdata;
    logic              cpu_resp;
    logic [addr_w-1:0] mem_addr;
    logic              mem_read;
    logic [line_w-1:0] mem_rdata;
    logic              mem_resp;

    logic [addr_w-1:0] read_log [$];     // line addresses served
    logic [addr_w-1:0] pf_allowed [$];   // next lines of offset-zero fetches
    logic              mem_busy;
    int                mem_wait;
    logic [addr_w-1:0] mem_line;
    logic              read_seen;
    logic [addr_w-1:0] addr_seen;
    logic [15:0]       lfsr = 16'd46321;
    int                cycles = 0;
    int                value_errors = 0;
    int                other_errors = 0;
    int                total;

    icache icache_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_read  (cpu_read),
        .cpu_rdata (cpu_rdata),
        .cpu_resp  (cpu_resp),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    bind icache icache_checker checker_inst (
        .clk      (clk),
        .rst      (rst),
        .cpu_read (cpu_read),
        .cpu_resp (cpu_resp),
        .mem_addr (mem_addr),
        .mem_read (mem_read),
        .mem_resp (mem_resp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run stopped after %0d cycles before the tests finished", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address rules and line memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [addr_w-1:0] line_of(input logic [addr_w-1:0] addr);
        return addr & ~addr_w'(line_bytes - 1);
    endfunction

    function automatic logic [word_w-1:0] expected_word(input logic [addr_w-1:0] addr);
        return {addr[addr_w-1:2], 2'b00} ^ fill_pattern;
    endfunction

    function automatic logic [line_w-1:0] line_data(input logic [addr_w-1:0] base);
        logic [line_w-1:0] line;
        for (int i = 0; i < line_w / word_w; i++) begin
            line[i*word_w +: word_w] = (line_of(base) + addr_w'(4 * i)) ^ fill_pattern;
        end
        return line;
    endfunction

    always @(posedge clk) begin
        read_seen = mem_read;   // pre-edge values
        addr_seen = mem_addr;
        #1;
        if (mem_resp) begin
            mem_resp  = 1'b0;
            mem_rdata = '0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_resp  = 1'b1;
                mem_rdata = line_data(mem_line);
                mem_busy  = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end else if (read_seen === 1'b1) begin
            mem_busy = 1'b1;
            mem_line = addr_seen;
            mem_wait = mem_latency - 1;
            read_log.push_back(addr_seen);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic is_prefetch_target(input logic [addr_w-1:0] addr);
        foreach (pf_allowed[i]) begin
            if (pf_allowed[i] == addr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_word(input string name, input logic [word_w-1:0] expected,
                              input logic [word_w-1:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_w-1:0] expected,
                              input logic [addr_w-1:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic expect_read_count(input int n);
        if (read_log.size() != n) begin
            other_errors++;
            $display("expected %0d memory reads but saw %0d", n, read_log.size());
        end
    endtask

    task automatic wait_reads(input int n);
        int waited;
        waited = 0;
        while (read_log.size() < n && waited < resp_limit) begin
            @(negedge clk);
            waited++;
        end
        if (read_log.size() < n) begin
            other_errors++;
            $display("the expected prefetch read never reached the memory port");
        end
    endtask

    // one CPU fetch, held until cpu_resp
    task automatic fetch(input logic [addr_w-1:0] addr);
        int   waited;
        logic got;
        waited = 0;
        got    = 1'b0;
        @(posedge clk);
        #1;
        cpu_addr = addr;
        cpu_read = 1'b1;
        while (!got && waited < resp_limit) begin
            @(negedge clk);
            if (cpu_resp === 1'b1) begin
                got = 1'b1;
                check_word("cpu_rdata", expected_word(addr), cpu_rdata);
            end else begin
                waited++;
            end
        end
        if (!got) begin
            other_errors++;
            $display("fetch at %h got no cpu_resp within %0d cycles", addr, resp_limit);
        end
        @(posedge clk);
        #1;
        cpu_read = 1'b0;    // address stays put for the prefetch cycle
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset();
        repeat (6) begin
            @(negedge clk);
            if (cpu_resp !== 1'b0 || mem_read !== 1'b0) begin
                other_errors++;
                $display("cpu_resp or mem_read active after reset with no fetch presented");
            end
        end
    endtask

    task automatic test_cold_miss();
        read_log.delete();
        fetch(32'h0000_1008);   // miss, fills line 0x1000
        fetch(32'h0000_1004);
        fetch(32'h0000_101c);
        fetch(32'h0000_1010);
        expect_read_count(1);
        if (read_log.size() > 0) begin
            check_addr("mem_addr", 32'h0000_1000, read_log[0]);
        end
    endtask

    task automatic test_prefetch();
        read_log.delete();
        fetch(32'h0000_2040);   // offset zero
        wait_reads(2);
        fetch(32'h0000_2068);   // served from the prefetched line
        expect_read_count(2);
        if (read_log.size() >= 2) begin
            check_addr("mem_addr", 32'h0000_2040, read_log[0]);
            check_addr("mem_addr", 32'h0000_2060, read_log[1]);
        end
    endtask

    task automatic test_conflict();
        logic [addr_w-1:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = i[0] ? 32'h0000_4084 : 32'h0000_3084;   // both set 4
            read_log.delete();
            fetch(addr);
            expect_read_count(1);
            if (read_log.size() > 0) begin
                check_addr("mem_addr", line_of(addr), read_log[0]);
            end
        end
    endtask

    task automatic test_random_walk();
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] seen;
        pf_allowed.delete();
        read_log.delete();
        for (int i = 0; i < walk_fetches; i++) begin
            addr = 32'h0000_5000 | (addr_w'(take_bits(7)) << 2);
            if (addr[offset_w-1:0] == '0) begin
                pf_allowed.push_back(line_of(addr) + addr_w'(line_bytes));
            end
            fetch(addr);
            while (read_log.size() > 0) begin
                seen = read_log.pop_front();
                if (!is_prefetch_target(seen)) begin
                    check_addr("mem_addr", line_of(addr), seen);
                end
            end
        end
    endtask

    initial begin
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_read  = 1'b0;
        mem_rdata = '0;
        mem_resp  = 1'b0;
        mem_busy  = 1'b0;
        mem_wait  = 0;
        mem_line  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_cold_miss();
        test_prefetch();
        test_conflict();
        test_random_walk();
        repeat (4) @(posedge clk);

        total = value_errors + other_errors + icache_inst.checker_inst.fails;
        $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errors, other_errors, icache_inst.checker_inst.fails);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : icache_tb

// File: tb/icache_checker.sv
`timescale 1ns/10ps

module icache_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cpu_read,
    input  logic                           cpu_resp,
    input  logic [cache_types::addr_w-1:0] mem_addr,
    input  logic                           mem_read,
    input  logic                           mem_resp
);

    int fails = 0;  // failed assertions so far

    mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_read && !mem_resp |=> mem_read && $stable(mem_addr))
    else begin
        $error("mem_read dropped or mem_addr moved before mem_resp");
        fails++;
    end

    resp_in_fetch: assert property (@(posedge clk) disable iff (rst)
        cpu_resp |-> cpu_read)
    else begin
        $error("cpu_resp with no fetch presented");
        fails++;
    end

    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_resp |=> !cpu_resp)
    else begin
        $error("cpu_resp held for more than one cycle");
        fails++;
    end

endmodule : icache_checker

// File: verilog/icache.sv
`timescale 1ns/10ps

module icache (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cache_types::addr_w-1:0] cpu_addr,
    input  logic                           cpu_read,
    output logic [cache_types::word_w-1:0] cpu_rdata,
    output logic                           cpu_resp,
    output logic [cache_types::addr_w-1:0] mem_addr,
    output logic                           mem_read,
    input  logic [cache_types::line_w-1:0] mem_rdata,
    input  logic                           mem_resp
);
    import cache_types::*;

    state_t            state;
    logic              valid_hit;
    logic              prefetch;
    logic              prefetch_rvalid;
    logic              ack;
    logic [addr_w-1:0] pf_addr;
    logic [line_w-1:0] pf_line;

    mem_if fill_ch ();   // miss fill
    mem_if pf_ch ();     // next-line prefetch

    inst_control control (
        .clk             (clk),
        .rst             (rst),
        .valid_cpu_rqst  (cpu_read),
        .valid_hit       (valid_hit),
        .mem_resp        (fill_ch.resp),
        .offset          (cpu_addr[offset_w-1:0]),
        .prefetch_rvalid (prefetch_rvalid),
        .prefetch        (prefetch),
        .ack             (ack),
        .active_prefetch (),
        .state           (state)
    );

    inst_datapath datapath (
        .clk             (clk),
        .rst             (rst),
        .state           (state),
        .cpu_addr        (cpu_addr),
        .cpu_rdata       (cpu_rdata),
        .cpu_resp        (cpu_resp),
        .valid_hit       (valid_hit),
        .fill_ch         (fill_ch),
        .prefetch_rvalid (prefetch_rvalid),
        .pf_addr         (pf_addr),
        .pf_line         (pf_line)
    );

    prefetch_unit prefetcher (
        .clk             (clk),
        .rst             (rst),
        .state           (state),
        .cpu_addr        (cpu_addr),
        .prefetch        (prefetch),
        .prefetch_rvalid (prefetch_rvalid),
        .pf_addr         (pf_addr),
        .pf_line         (pf_line),
        .pf_ch           (pf_ch)
    );

    mem_arbiter arbiter (
        .clk       (clk),
        .rst       (rst),
        .fill_ch   (fill_ch),
        .pf_ch     (pf_ch),
        .ack       (ack),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

endmodule : icache

// File: verilog/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                           clk,
    input  logic                           rst,
    mem_if.server                          fill_ch,
    mem_if.server                          pf_ch,
    output logic                           ack,
    output logic [cache_types::addr_w-1:0] mem_addr,
    output logic                           mem_read,
    input  logic [cache_types::line_w-1:0] mem_rdata,
    input  logic                           mem_resp
);
    import cache_types::*;

    logic busy;       // grant held until resp
    logic owner_pf;   // held grant belongs to pf_ch
    logic sel_pf;     // pf_ch owns the port this cycle

    // fill first when free
    assign sel_pf = busy ? owner_pf : (!fill_ch.read && pf_ch.read);

    assign mem_addr = sel_pf ? pf_ch.addr : fill_ch.addr;
    assign mem_read = sel_pf ? pf_ch.read : fill_ch.read;

    assign ack = !busy && sel_pf;   // new prefetch grant

    assign fill_ch.resp  = mem_resp && !sel_pf;
    assign pf_ch.resp    = mem_resp && sel_pf;
    assign fill_ch.rdata = sel_pf ? '0 : mem_rdata;
    assign pf_ch.rdata   = sel_pf ? mem_rdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            owner_pf <= 1'b0;
        end else if (mem_resp) begin
            busy <= 1'b0;
        end else if (mem_read && !busy) begin
            busy     <= 1'b1;
            owner_pf <= sel_pf;
        end
    end

endmodule : mem_arbiter

// File: verilog/prefetch_unit.sv
`timescale 1ns/10ps

module prefetch_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  cache_types::state_t            state,
    input  logic [cache_types::addr_w-1:0] cpu_addr,
    output logic                           prefetch,
    output logic                           prefetch_rvalid,
    output logic [cache_types::addr_w-1:0] pf_addr,
    output logic [cache_types::line_w-1:0] pf_line,
    mem_if.client                          pf_ch
);
    import cache_types::*;

    logic              req_q;       // read outstanding on pf_ch
    logic [addr_w-1:0] next_line;

    // base of the line after the current fetch
    assign next_line = {cpu_addr[addr_w-1:offset_w], {offset_w{1'b0}}} + addr_w'(line_bytes);

    assign prefetch = (state == prefetch_s);   // prefetch_s lasts one cycle

    assign pf_ch.addr = pf_addr;
    assign pf_ch.read = req_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request and buffer control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q           <= 1'b0;
            prefetch_rvalid <= 1'b0;
        end else begin
            if (prefetch) begin
                req_q <= 1'b1;
            end else if (pf_ch.resp) begin
                req_q <= 1'b0;
            end

            if (pf_ch.resp) begin
                prefetch_rvalid <= 1'b1;
            end else if (state == idle_s && prefetch_rvalid) begin
                prefetch_rvalid <= 1'b0;    // installed this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prefetch) begin
            pf_addr <= next_line;
        end
        if (pf_ch.resp) begin
            pf_line <= pf_ch.rdata;
        end
    end

endmodule : prefetch_unit

// File: verilog/inst_datapath.sv
`timescale 1ns/10ps

module inst_datapath (
    input  logic                           clk,
    input  logic                           rst,
    input  cache_types::state_t            state,
    input  logic [cache_types::addr_w-1:0] cpu_addr,
    output logic [cache_types::word_w-1:0] cpu_rdata,
    output logic                           cpu_resp,
    output logic                           valid_hit,
    mem_if.client                          fill_ch,
    input  logic                           prefetch_rvalid,
    input  logic [cache_types::addr_w-1:0] pf_addr,
    input  logic [cache_types::line_w-1:0] pf_line
);
    import cache_types::*;

    logic [tag_w-1:0]    tag_arr  [num_sets];
    logic [line_w-1:0]   data_arr [num_sets];
    logic [num_sets-1:0] valid_arr;

    logic [index_w-1:0] cpu_index;
    logic [tag_w-1:0]   cpu_tag;
    logic [index_w-1:0] pf_index;
    logic [tag_w-1:0]   pf_tag;

    logic               fill_done;   // resp already seen in this allocate_s
    logic               wr_en;
    logic [index_w-1:0] wr_index;
    logic [tag_w-1:0]   wr_tag;
    logic [line_w-1:0]  wr_line;

    assign cpu_index = cpu_addr[offset_w +: index_w];
    assign cpu_tag   = cpu_addr[addr_w-1 -: tag_w];
    assign pf_index  = pf_addr[offset_w +: index_w];
    assign pf_tag    = pf_addr[addr_w-1 -: tag_w];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign valid_hit = valid_arr[cpu_index] && (tag_arr[cpu_index] == cpu_tag);
    assign cpu_resp  = (state == compare_tag_s) && valid_hit;
    assign cpu_rdata = data_arr[cpu_index][cpu_addr[offset_w-1:2] * word_w +: word_w];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // miss fill request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign fill_ch.addr = {cpu_addr[addr_w-1:offset_w], {offset_w{1'b0}}};
    assign fill_ch.read = (state == allocate_s) && !fill_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_done <= 1'b0;
        end else if (state != allocate_s) begin
            fill_done <= 1'b0;
        end else if (fill_ch.resp) begin
            fill_done <= 1'b1;   // drop read until state moves on
        end
    end

    // install from a fill, or from the prefetch buffer while idle
    always_comb begin
        wr_en    = 1'b0;
        wr_index = cpu_index;
        wr_tag   = cpu_tag;
        wr_line  = fill_ch.rdata;
        if (fill_ch.resp) begin
            wr_en = 1'b1;
        end else if (state == idle_s && prefetch_rvalid) begin
            wr_en    = 1'b1;
            wr_index = pf_index;
            wr_tag   = pf_tag;
            wr_line  = pf_line;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_arr[wr_index]  <= wr_tag;
            data_arr[wr_index] <= wr_line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
        end else if (wr_en) begin
            valid_arr[wr_index] <= 1'b1;
        end
    end

endmodule : inst_datapath

// File: verilog/inst_control.sv
`timescale 1ns/10ps

module inst_control (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             valid_cpu_rqst,
    input  logic                             valid_hit,
    input  logic                             mem_resp,
    input  logic [cache_types::offset_w-1:0] offset,
    input  logic                             prefetch_rvalid,
    input  logic                             prefetch,
    input  logic                             ack,
    output logic                             active_prefetch,
    output cache_types::state_t              state
);
    import cache_types::*;

    state_t next_state;
    logic   mem_resp_q;     // fill resp, one cycle late
    logic   hit_q;          // hit result from compare_tag_s

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state and prefetch bookkeeping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= idle_s;
            mem_resp_q      <= 1'b0;
            hit_q           <= 1'b0;
            active_prefetch <= 1'b0;
        end else begin
            state      <= next_state;
            mem_resp_q <= mem_resp;

            if (state == compare_tag_s) begin
                hit_q <= valid_hit;
            end

            if (prefetch) begin
                active_prefetch <= 1'b1;
            end else if (state == idle_s && prefetch_rvalid) begin
                active_prefetch <= 1'b0;     // line went into the arrays
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state = state;
        case (state)
            idle_s: begin
                // a waiting prefetched line is installed first
                if (valid_cpu_rqst && !prefetch_rvalid) begin
                    next_state = compare_tag_s;
                end
            end
            compare_tag_s: begin
                if (offset == '0 && !active_prefetch) begin
                    next_state = prefetch_s;
                end else if (!valid_hit && active_prefetch) begin
                    next_state = idle_s;     // let the prefetch land, then retry
                end else if (valid_hit) begin
                    next_state = idle_s;
                end else begin
                    next_state = allocate_s;
                end
            end
            prefetch_s: begin
                if (hit_q) begin
                    next_state = post_prefetch_s;
                end else begin
                    next_state = allocate_s;
                end
            end
            post_prefetch_s: begin
                if (ack) begin
                    next_state = idle_s;     // arbiter took the read
                end
            end
            allocate_s: begin
                if (mem_resp_q) begin
                    next_state = compare_tag_s;
                end
            end
            default: begin
                next_state = idle_s;
            end
        endcase
    end

endmodule : inst_control

// File: verilog/mem_if.sv
`timescale 1ns/10ps

interface mem_if;
    import cache_types::*;

    logic [addr_w-1:0] addr;    // line base address
    logic              read;
    logic [line_w-1:0] rdata;   // whole line
    logic              resp;    // rdata valid this cycle

    modport client (
        output addr,
        output read,
        input  rdata,
        input  resp
    );

    modport server (
        input  addr,
        input  read,
        output rdata,
        output resp
    );
endinterface : mem_if

// File: verilog/cache_types.sv
package cache_types;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int addr_w     = 32;    // byte address
    localparam int line_w     = 256;   // one cache line
    localparam int word_w     = 32;    // one fetch word
    localparam int num_sets   = 8;     // direct mapped
    localparam int line_bytes = 32;    // next-line stride

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int offset_w = 5;                            // byte in line
    localparam int index_w  = 3;                            // set select
    localparam int tag_w    = addr_w - index_w - offset_w;  // 24 bits

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        idle_s,             // waiting for a fetch or a prefetch install
        compare_tag_s,      // tag lookup, answers on a hit
        prefetch_s,         // kicks off the next-line read
        post_prefetch_s,    // waits for the arbiter to take it
        allocate_s          // line fill from memory
    } state_t;

endpackage : cache_types
